//--- rtl/rd_cpl_output.sv
/* Two-entry output FIFO, entry 0 drives the application directly.
   Pops the tag table while entry 1 is empty. */

`timescale 1ns/1ps

module rd_cpl_output import rd_reorder_pkg::*; (
    input  logic     aclk,
    input  logic     aresetn,

    // From the tag table head
    input  logic     head_valid,
    input  app_cpl_t head,
    output logic     head_pop,

    // Application completion channel
    output logic     cpl_valid,
    output app_cpl_t cpl,
    input  logic     cpl_ready
);

    logic     v0;
    logic     v1;
    app_cpl_t ent0;
    app_cpl_t ent1;
    logic     push;
    logic     pop;

    // Room exists whenever the second entry is empty
    assign head_pop = head_valid && !v1;
    assign push     = head_pop;
    assign pop      = v0 && cpl_ready;

    ////////////////////
    // Occupancy
    ////////////////////

    // v1 only set while v0 is set
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            v0 <= 1'b0;
            v1 <= 1'b0;
        end else begin
            v0 <= v1 || (v0 && !pop) || push;
            v1 <= (v1 && !pop) || (push && v0 && !pop);
        end
    end

    ////////////////////
    // Entries
    ////////////////////

    always_ff @(posedge aclk) begin
        // Shift the waiting entry forward, or take the head directly
        if (pop && v1) begin
            ent0 <= ent1;
        end else if (push && (!v0 || pop)) begin
            ent0 <= head;
        end
        // Park the head behind a stalled entry 0
        if (push && v0 && !pop) begin
            ent1 <= head;
        end
    end

    assign cpl_valid = v0;
    assign cpl       = ent0;

endmodule

//--- rtl/rd_reorder_consts.svh
/* Sizes and address map of the read reorder path.
   RD_NB_TAG must stay a power of two so the tag pointers wrap on their own. */

`ifndef RD_REORDER_CONSTS_SVH
`define RD_REORDER_CONSTS_SVH

////////////////////
// Capacity
////////////////////

// Outstanding requests per fetch port
`define RD_OSTD_NUM     4
// Two ports share the tag pool, so twice the per-port depth
`define RD_NB_TAG       (2 * `RD_OSTD_NUM)
// Index width of a tag, log2 of RD_NB_TAG
`define RD_TAG_W        3

////////////////////
// Bus widths
////////////////////

`define RD_ID_W         8
`define RD_ADDR_W       16
`define RD_DATA_W       32
`define RD_RESP_W       2

// Pattern XORed onto every fetch tag
`define RD_ID_MASK      8'h20

// Uncached IO window, bounds inclusive
`define RD_IO_BASE      16'h8000
`define RD_IO_TOP       16'h8fff

`endif

//--- rtl/rd_reorder_pkg.sv
/* Types shared by the reorder RTL and its testbench.
   Field widths come from the consts header. */

`include "rd_reorder_consts.svh"

package rd_reorder_pkg;

    ////////////////////
    // Enums
    ////////////////////

    // Tag life cycle, FREE then RSVD on issue, RCVD on completion
    typedef enum logic [1:0] {
        TAG_FREE = 2'b00,
        TAG_RSVD = 2'b01,
        TAG_RCVD = 2'b11
    } tag_state_e;

    // Fetch port picked by the address decoder
    typedef enum logic {
        ROUTE_BLK = 1'b0,
        ROUTE_IO  = 1'b1
    } route_e;

    ////////////////////
    // Payloads
    ////////////////////

    // Application read request
    typedef struct packed {
        logic [`RD_ADDR_W-1:0] addr;
        logic [`RD_ID_W-1:0]   id;
    } rd_req_t;

    // Request toward a fetcher, tag already masked
    typedef struct packed {
        logic [`RD_ADDR_W-1:0] addr;
        logic [`RD_ID_W-1:0]   tag;
    } fetch_req_t;

    // Completion from a fetcher, still carrying the masked tag
    typedef struct packed {
        logic [`RD_ID_W-1:0]   tag;
        logic [`RD_RESP_W-1:0] resp;
        logic [`RD_DATA_W-1:0] data;
    } rd_cpl_t;

    // Completion back to the application with its original ID
    typedef struct packed {
        logic [`RD_ID_W-1:0]   id;
        logic [`RD_RESP_W-1:0] resp;
        logic [`RD_DATA_W-1:0] data;
    } app_cpl_t;

endpackage

//--- rtl/rd_reorder_top.sv
/* Read reorder path of the data cache, fetchers sit outside.
   Completion inputs have no ready and are taken every cycle they are valid. */

`timescale 1ns/1ps

`include "rd_reorder_consts.svh"

module rd_reorder_top import rd_reorder_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,

    // Application requests
    input  logic       req_valid,
    output logic       req_ready,
    input  rd_req_t    req,

    // IO fetcher
    output logic       io_fetch_valid,
    input  logic       io_fetch_ready,
    output fetch_req_t io_fetch,
    input  logic       io_cpl_valid,
    input  rd_cpl_t    io_cpl,

    // Block fetcher
    output logic       blk_fetch_valid,
    input  logic       blk_fetch_ready,
    output fetch_req_t blk_fetch,
    input  logic       blk_cpl_valid,
    input  rd_cpl_t    blk_cpl,

    // Application completions
    output logic       cpl_valid,
    input  logic       cpl_ready,
    output app_cpl_t   cpl,

    output logic       pending_rd
);

    ////////////////////
    // Internal links
    ////////////////////

    // Router to tag table
    logic [`RD_ID_W-1:0] next_tag;
    logic                tag_free;
    logic                tag_req;
    logic [`RD_ID_W-1:0] tag_id;

    // Tag table to output stage
    logic                head_valid;
    app_cpl_t            head;
    logic                head_pop;

    rd_req_router u_rd_req_router (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .next_tag        (next_tag),
        .tag_free        (tag_free),
        .tag_req         (tag_req),
        .tag_id          (tag_id),
        .io_fetch_valid  (io_fetch_valid),
        .io_fetch        (io_fetch),
        .io_fetch_ready  (io_fetch_ready),
        .blk_fetch_valid (blk_fetch_valid),
        .blk_fetch       (blk_fetch),
        .blk_fetch_ready (blk_fetch_ready)
    );

    rd_tag_table u_rd_tag_table (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .tag_req       (tag_req),
        .tag_id        (tag_id),
        .next_tag      (next_tag),
        .tag_free      (tag_free),
        .io_cpl_valid  (io_cpl_valid),
        .io_cpl        (io_cpl),
        .blk_cpl_valid (blk_cpl_valid),
        .blk_cpl       (blk_cpl),
        .head_valid    (head_valid),
        .head          (head),
        .head_pop      (head_pop),
        .pending_rd    (pending_rd)
    );

    rd_cpl_output u_rd_cpl_output (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop),
        .cpl_valid  (cpl_valid),
        .cpl        (cpl),
        .cpl_ready  (cpl_ready)
    );

endmodule

//--- rtl/rd_req_router.sv
/* Routes requests by address to one registered slot per fetch port.
   req_ready follows req_valid, so it stays low while no request is offered. */

`timescale 1ns/1ps

`include "rd_reorder_consts.svh"

module rd_req_router import rd_reorder_pkg::*; (
    input  logic                aclk,
    input  logic                aresetn,

    // Application request channel
    input  logic                req_valid,
    input  rd_req_t             req,
    output logic                req_ready,

    // Tag allocation toward the tag table
    input  logic [`RD_ID_W-1:0] next_tag,
    input  logic                tag_free,
    output logic                tag_req,
    output logic [`RD_ID_W-1:0] tag_id,

    // Fetch ports
    output logic                io_fetch_valid,
    output fetch_req_t          io_fetch,
    input  logic                io_fetch_ready,
    output logic                blk_fetch_valid,
    output fetch_req_t          blk_fetch,
    input  logic                blk_fetch_ready
);

    ////////////////////
    // Decode and accept
    ////////////////////

    route_e     route;
    logic       accept;
    // Slot state indexed by route_e
    logic [1:0] slot_valid;
    logic [1:0] slot_ready;
    fetch_req_t slot_q [2];

    // IO window check, everything else is cacheable
    assign route = (req.addr >= `RD_IO_BASE && req.addr <= `RD_IO_TOP) ? ROUTE_IO : ROUTE_BLK;

    // Only the targeted slot needs to be empty
    // a full IO slot does not stall block traffic
    assign req_ready = req_valid && tag_free && !slot_valid[route];
    assign accept    = req_valid && req_ready;

    // Reserve the tag in the same cycle, ID goes along for storage
    assign tag_req = accept;
    assign tag_id  = req.id;

    ////////////////////
    // Fetch slots
    ////////////////////

    assign slot_ready[ROUTE_IO]  = io_fetch_ready;
    assign slot_ready[ROUTE_BLK] = blk_fetch_ready;

    // Each slot drains on its own handshake and fills on accept
    // A slot is only loaded when empty so the two never collide
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            slot_valid <= 2'b00;
        end else begin
            slot_valid <= (slot_valid & ~slot_ready) | (accept ? (2'b01 << route) : 2'b00);
        end
    end

    // Payload held until the fetcher takes it
    always_ff @(posedge aclk) begin
        if (accept) begin
            slot_q[route] <= fetch_req_t'{addr: req.addr, tag: next_tag};
        end
    end

    assign io_fetch_valid  = slot_valid[ROUTE_IO];
    assign io_fetch        = slot_q[ROUTE_IO];
    assign blk_fetch_valid = slot_valid[ROUTE_BLK];
    assign blk_fetch       = slot_q[ROUTE_BLK];

endmodule

//--- rtl/rd_tag_table.sv
/* Circular tag pool that stores completions and hands them back in issue order.
   Fetchers must only return tags that were issued, at most one strobe per tag. */

`timescale 1ns/1ps

`include "rd_reorder_consts.svh"

module rd_tag_table import rd_reorder_pkg::*; (
    input  logic                aclk,
    input  logic                aresetn,

    // Allocation side, driven by the router
    input  logic                tag_req,
    input  logic [`RD_ID_W-1:0] tag_id,
    output logic [`RD_ID_W-1:0] next_tag,
    output logic                tag_free,

    // Completion strobes, always accepted
    input  logic                io_cpl_valid,
    input  rd_cpl_t             io_cpl,
    input  logic                blk_cpl_valid,
    input  rd_cpl_t             blk_cpl,

    // In-order head toward the output stage
    output logic                head_valid,
    output app_cpl_t            head,
    input  logic                head_pop,

    output logic                pending_rd
);

    ////////////////////
    // Storage
    ////////////////////

    tag_state_e             tag_state [`RD_NB_TAG];
    // Original application IDs, written at issue
    logic [`RD_ID_W-1:0]    id_ram    [`RD_NB_TAG];
    // Completion payloads, written on strobe
    logic [`RD_RESP_W-1:0]  resp_ram  [`RD_NB_TAG];
    logic [`RD_DATA_W-1:0]  data_ram  [`RD_NB_TAG];

    // Next tag to issue and next tag to release
    logic [`RD_TAG_W-1:0]   req_ptr;
    logic [`RD_TAG_W-1:0]   cpl_ptr;

    // Tags with the bus mask stripped
    logic [`RD_ID_W-1:0]    io_tag_um;
    logic [`RD_ID_W-1:0]    blk_tag_um;
    logic [`RD_TAG_W-1:0]   io_idx;
    logic [`RD_TAG_W-1:0]   blk_idx;

    assign io_tag_um  = io_cpl.tag ^ `RD_ID_MASK;
    assign blk_tag_um = blk_cpl.tag ^ `RD_ID_MASK;
    // Upper bits are zero once the mask is gone
    assign io_idx     = io_tag_um[`RD_TAG_W-1:0];
    assign blk_idx    = blk_tag_um[`RD_TAG_W-1:0];

    ////////////////////
    // Allocation
    ////////////////////

    // Masked tag for the fetch bus
    assign next_tag = {{(`RD_ID_W - `RD_TAG_W){1'b0}}, req_ptr} ^ `RD_ID_MASK;
    // Issue only when the slot under the pointer has drained
    assign tag_free = (tag_state[req_ptr] == TAG_FREE);

    ////////////////////
    // Tag states
    ////////////////////

    // Issue, completion and release never hit the same tag in one cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `RD_NB_TAG; i++) begin
                tag_state[i] <= TAG_FREE;
            end
        end else begin
            for (int i = 0; i < `RD_NB_TAG; i++) begin
                if (tag_req && req_ptr == i[`RD_TAG_W-1:0]) begin
                    tag_state[i] <= TAG_RSVD;
                end else if (io_cpl_valid && io_idx == i[`RD_TAG_W-1:0]) begin
                    tag_state[i] <= TAG_RCVD;
                end else if (blk_cpl_valid && blk_idx == i[`RD_TAG_W-1:0]) begin
                    tag_state[i] <= TAG_RCVD;
                end else if (head_pop && cpl_ptr == i[`RD_TAG_W-1:0]) begin
                    tag_state[i] <= TAG_FREE;
                end
            end
        end
    end

    // Pointers wrap naturally over the power-of-two pool
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req_ptr <= '0;
            cpl_ptr <= '0;
        end else begin
            if (tag_req) begin
                req_ptr <= req_ptr + 1'b1;
            end
            if (head_pop) begin
                cpl_ptr <= cpl_ptr + 1'b1;
            end
        end
    end

    ////////////////////
    // Payload stores
    ////////////////////

    always_ff @(posedge aclk) begin
        if (tag_req) begin
            id_ram[req_ptr] <= tag_id;
        end
        // Both ports may land in one cycle on different tags
        if (io_cpl_valid) begin
            resp_ram[io_idx] <= io_cpl.resp;
            data_ram[io_idx] <= io_cpl.data;
        end
        if (blk_cpl_valid) begin
            resp_ram[blk_idx] <= blk_cpl.resp;
            data_ram[blk_idx] <= blk_cpl.data;
        end
    end

    ////////////////////
    // Head release
    ////////////////////

    // Head is offered once its completion has been stored
    assign head_valid = (tag_state[cpl_ptr] == TAG_RCVD);
    assign head       = app_cpl_t'{id:   id_ram[cpl_ptr],
                                   resp: resp_ram[cpl_ptr],
                                   data: data_ram[cpl_ptr]};

    // Busy while any tag is reserved or waiting for release
    always_comb begin
        pending_rd = 1'b0;
        for (int i = 0; i < `RD_NB_TAG; i++) begin
            if (tag_state[i] != TAG_FREE) begin
                pending_rd = 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the read reorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f sources.f --top-module tb_rd_reorder -Mdir obj_dir -o sim_rd_reorder
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rd_reorder)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+rtl
rtl/rd_reorder_pkg.sv
rtl/rd_req_router.sv
rtl/rd_tag_table.sv
rtl/rd_cpl_output.sv
rtl/rd_reorder_top.sv
test/tb_rd_reorder.sv

//--- test/tb_rd_reorder.sv
/* Testbench for the read reorder path with two fetcher models that reply out of order.
   The IO window is assumed to span 4 KB from RD_IO_BASE. */

`timescale 1ns/1ps

`include "rd_reorder_consts.svh"

module tb_rd_reorder import rd_reorder_pkg::*; ();

    localparam int TIMEOUT_CYC = 2000;
    localparam int NUM_FREE    = 40;
    localparam int NUM_BP      = 60;

    ////////////////////
    // DUT signals
    ////////////////////

    logic       aclk = 1'b0;
    logic       aresetn = 1'b0;
    logic       req_valid = 1'b0;
    logic       req_ready;
    rd_req_t    req = '0;
    logic       io_fetch_valid;
    logic       io_fetch_ready = 1'b0;
    fetch_req_t io_fetch;
    logic       io_cpl_valid = 1'b0;
    rd_cpl_t    io_cpl = '0;
    logic       blk_fetch_valid;
    logic       blk_fetch_ready = 1'b0;
    fetch_req_t blk_fetch;
    logic       blk_cpl_valid = 1'b0;
    rd_cpl_t    blk_cpl = '0;
    logic       cpl_valid;
    logic       cpl_ready = 1'b0;
    app_cpl_t   cpl;
    logic       pending_rd;

    ////////////////////
    // Testbench state
    ////////////////////

    int seed = 32'hdab4_7401;
    // Phase controls set by the main sequence
    logic hold_returns = 1'b0;
    logic rand_ready = 1'b0;
    logic [`RD_ID_W-1:0] next_id = '0;
    // Expected IDs and addresses in issue order
    logic [`RD_ID_W-1:0]   exp_id   [$];
    logic [`RD_ADDR_W-1:0] exp_addr [$];
    // Tags on the fetch bus that have not come back yet
    logic [`RD_NB_TAG-1:0] tag_busy = '0;
    logic     stalled_q = 1'b0;
    app_cpl_t stalled_cpl = '0;
    // Fetches held by the models in parallel queues
    fetch_req_t pend_req  [$];
    int         pend_port [$];
    int         pend_wait [$];
    int acc_count = 0;
    int cpl_count = 0;
    int chk_errors = 0;
    int seq_errors = 0;
    int route_errors = 0;
    int timeouts = 0;

    rd_reorder_top u_rd_reorder_top (.*);

    always #2 aclk = ~aclk;

    ////////////////////
    // Reference rules
    ////////////////////

    function automatic logic in_io(input logic [`RD_ADDR_W-1:0] addr);
        return (addr >= `RD_IO_BASE) && (addr <= `RD_IO_TOP);
    endfunction

    function automatic logic [`RD_DATA_W-1:0] data_for_addr(input logic [`RD_ADDR_W-1:0] addr);
        return {{(`RD_DATA_W - `RD_ADDR_W){1'b0}}, addr} ^ 32'h5a5a_0000;
    endfunction

    // Odd IO addresses answer with an error response
    function automatic logic [`RD_RESP_W-1:0] resp_for_addr(input logic [`RD_ADDR_W-1:0] addr);
        return (in_io(addr) && addr[0]) ? 2'b10 : 2'b00;
    endfunction

    ////////////////////
    // Checkers
    ////////////////////

    // IO window traffic only on io_fetch and the rest only on blk_fetch
    assert property (@(posedge aclk) disable iff (!aresetn)
        (!io_fetch_valid || in_io(io_fetch.addr)) &&
        (!blk_fetch_valid || !in_io(blk_fetch.addr)))
    else begin
        route_errors++;
        $display("[FAIL] %0t fetch on wrong port, io_fetch.addr %h blk_fetch.addr %h",
                 $time, io_fetch.addr, blk_fetch.addr);
    end

    task automatic check_fetch(input fetch_req_t f, input string port);
        logic [`RD_ID_W-1:0] tag_um;
        tag_um = f.tag ^ `RD_ID_MASK;
        // Upper bits vanish once the mask is removed
        assert (tag_um[`RD_ID_W-1:`RD_TAG_W] == '0) else begin
            chk_errors++;
            $display("[FAIL] %0t %s_fetch.tag got %h, mask %h not applied",
                     $time, port, f.tag, `RD_ID_MASK);
        end
        assert (!tag_busy[tag_um[`RD_TAG_W-1:0]]) else begin
            chk_errors++;
            $display("Tag %h issued on %s_fetch while still outstanding", f.tag, port);
        end
        tag_busy[tag_um[`RD_TAG_W-1:0]] = 1'b1;
    endtask

    initial begin
        logic [`RD_ID_W-1:0]   id_e;
        logic [`RD_ADDR_W-1:0] addr_e;
        logic [`RD_ID_W-1:0]   io_um;
        logic [`RD_ID_W-1:0]   blk_um;
        forever begin
            @(posedge aclk);
            if (aresetn) begin
                // Held completion must not move or vanish
                if (stalled_q) begin
                    assert (cpl_valid && cpl == stalled_cpl) else begin
                        chk_errors++;
                        $display("[FAIL] %0t cpl got %h expected %h under back-pressure",
                                 $time, cpl, stalled_cpl);
                    end
                end
                assert (tag_busy == '0 || pending_rd) else begin
                    chk_errors++;
                    $display("[FAIL] %0t pending_rd got 0 expected 1 with fetches outstanding",
                             $time);
                end
                io_um  = io_cpl.tag ^ `RD_ID_MASK;
                blk_um = blk_cpl.tag ^ `RD_ID_MASK;
                if (io_cpl_valid) begin
                    tag_busy[io_um[`RD_TAG_W-1:0]] = 1'b0;
                end
                if (blk_cpl_valid) begin
                    tag_busy[blk_um[`RD_TAG_W-1:0]] = 1'b0;
                end
                if (io_fetch_valid && io_fetch_ready) begin
                    check_fetch(io_fetch, "io");
                end
                if (blk_fetch_valid && blk_fetch_ready) begin
                    check_fetch(blk_fetch, "blk");
                end
                if (req_valid && req_ready) begin
                    exp_id.push_back(req.id);
                    exp_addr.push_back(req.addr);
                    acc_count++;
                end
                if (cpl_valid && cpl_ready) begin
                    cpl_count++;
                    if (exp_id.size() == 0) begin
                        chk_errors++;
                        $display("Completion id %h at %0t with no request outstanding",
                                 cpl.id, $time);
                    end else begin
                        id_e   = exp_id.pop_front();
                        addr_e = exp_addr.pop_front();
                        assert (cpl.id == id_e) else begin
                            chk_errors++;
                            $display("[FAIL] %0t cpl.id got %h expected %h",
                                     $time, cpl.id, id_e);
                        end
                        assert (cpl.data == data_for_addr(addr_e)) else begin
                            chk_errors++;
                            $display("[FAIL] %0t cpl.data got %h expected %h",
                                     $time, cpl.data, data_for_addr(addr_e));
                        end
                        assert (cpl.resp == resp_for_addr(addr_e)) else begin
                            chk_errors++;
                            $display("[FAIL] %0t cpl.resp got %b expected %b",
                                     $time, cpl.resp, resp_for_addr(addr_e));
                        end
                    end
                end
                stalled_q   = cpl_valid && !cpl_ready;
                stalled_cpl = cpl;
            end
        end
    end

    ////////////////////
    // Fetcher models
    ////////////////////

    // Pick one ripe entry of a port at random unless returns are held
    task automatic return_one(input int port, output logic valid, output rd_cpl_t pay);
        int n;
        int r;
        int k;
        int pick;
        n = 0;
        pick = -1;
        valid = 1'b0;
        pay = '0;
        for (k = 0; k < pend_port.size(); k++) begin
            if (pend_port[k] == port && pend_wait[k] == 0) begin
                n++;
            end
        end
        if (!hold_returns && n > 0) begin
            r = $unsigned($random(seed)) % n;
            for (k = 0; k < pend_port.size(); k++) begin
                if (pend_port[k] == port && pend_wait[k] == 0) begin
                    if (r == 0 && pick < 0) begin
                        pick = k;
                    end
                    r--;
                end
            end
            valid    = 1'b1;
            pay.tag  = pend_req[pick].tag;
            pay.resp = resp_for_addr(pend_req[pick].addr);
            pay.data = data_for_addr(pend_req[pick].addr);
            pend_req.delete(pick);
            pend_port.delete(pick);
            pend_wait.delete(pick);
        end
    endtask

    initial begin
        int k;
        forever begin
            @(posedge aclk);
            for (k = 0; k < pend_wait.size(); k++) begin
                if (pend_wait[k] > 0) begin
                    pend_wait[k] = pend_wait[k] - 1;
                end
            end
            // Port numbers follow route_e with IO as 1
            if (io_fetch_valid && io_fetch_ready) begin
                pend_req.push_back(io_fetch);
                pend_port.push_back(1);
                pend_wait.push_back($unsigned($random(seed)) % 13);
            end
            if (blk_fetch_valid && blk_fetch_ready) begin
                pend_req.push_back(blk_fetch);
                pend_port.push_back(0);
                pend_wait.push_back($unsigned($random(seed)) % 13);
            end
            #1;
            io_fetch_ready  = hold_returns || (($random(seed) & 3) != 0);
            blk_fetch_ready = hold_returns || (($random(seed) & 3) != 0);
            cpl_ready       = !rand_ready || (($random(seed) & 1) != 0);
            return_one(1, io_cpl_valid, io_cpl);
            return_one(0, blk_cpl_valid, blk_cpl);
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Half of the requests land in the IO window
    task automatic make_req(output rd_req_t r);
        logic [31:0] rnd;
        rnd = $random(seed);
        r.addr = rnd[16] ? (`RD_IO_BASE | {4'h0, rnd[11:0]}) : rnd[15:0];
        r.id = next_id;
        next_id = next_id + 1'b1;
    endtask

    task automatic send_req(input rd_req_t r);
        int waited;
        req = r;
        req_valid = 1'b1;
        waited = 0;
        do begin
            @(posedge aclk);
            waited++;
        end while (!req_ready && waited < TIMEOUT_CYC);
        if (!req_ready) begin
            timeouts++;
            $display("Timeout at %0t, request id %h never accepted", $time, r.id);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (cpl_count != acc_count && waited < TIMEOUT_CYC) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (cpl_count != acc_count) begin
            timeouts++;
            $display("Timeout at %0t, %0d completions still missing",
                     $time, acc_count - cpl_count);
        end
    endtask

    task automatic check_idle(input string when);
        assert ({req_ready, cpl_valid, io_fetch_valid, blk_fetch_valid, pending_rd} == 5'b0)
        else begin
            seq_errors++;
            $display("[FAIL] %0t %s %s got %b expected 00000", $time, when,
                     "{req_ready,cpl_valid,io/blk_fetch_valid,pending_rd}",
                     {req_ready, cpl_valid, io_fetch_valid, blk_fetch_valid, pending_rd});
        end
    endtask

    initial begin
        rd_req_t r;
        logic    accepted;
        int      n;
        int      idle;
        int      base;
        int      total;
        repeat (3) begin
            @(posedge aclk);
            #1;
            check_idle("in reset");
        end
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        check_idle("after reset");

        // Free-flowing completions followed by random back-pressure
        for (n = 0; n < NUM_FREE; n++) begin
            make_req(r);
            send_req(r);
        end
        rand_ready = 1'b1;
        for (n = 0; n < NUM_BP; n++) begin
            make_req(r);
            send_req(r);
        end
        wait_drain();
        rand_ready = 1'b0;

        // Fetchers accept but never answer so the tag pool runs dry
        hold_returns = 1'b1;
        base = acc_count;
        make_req(r);
        req = r;
        req_valid = 1'b1;
        idle = 0;
        n = 0;
        while (idle < 20 && n < TIMEOUT_CYC) begin
            @(posedge aclk);
            n++;
            accepted = req_ready;
            idle = accepted ? 0 : idle + 1;
            #1;
            if (accepted) begin
                make_req(r);
                req = r;
            end
        end
        req_valid = 1'b0;
        if (n >= TIMEOUT_CYC) begin
            timeouts++;
            $display("Timeout at %0t, req_ready never stayed low with returns held", $time);
        end
        assert (acc_count - base == `RD_NB_TAG) else begin
            seq_errors++;
            $display("[FAIL] %0t accepted requests got %0d expected %0d",
                     $time, acc_count - base, `RD_NB_TAG);
        end
        assert (pending_rd) else begin
            seq_errors++;
            $display("[FAIL] %0t pending_rd got 0 expected 1 with tags in flight", $time);
        end
        hold_returns = 1'b0;
        wait_drain();
        assert (!pending_rd) else begin
            seq_errors++;
            $display("[FAIL] %0t pending_rd got 1 expected 0 after drain", $time);
        end

        // Every request of the three phases comes back exactly once
        assert (cpl_count == NUM_FREE + NUM_BP + `RD_NB_TAG) else begin
            seq_errors++;
            $display("[FAIL] %0t completion count got %0d expected %0d",
                     $time, cpl_count, NUM_FREE + NUM_BP + `RD_NB_TAG);
        end
        total = chk_errors + seq_errors + route_errors + timeouts;
        $write("Requests %0d completions %0d check errors %0d ",
               acc_count, cpl_count, chk_errors);
        $display("sequence errors %0d route errors %0d timeouts %0d",
                 seq_errors, route_errors, timeouts);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
